/* Makefile */
# Verilator flow for the ALU register block

SIM = obj_dir/aluSim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --top-module aluTb -f aluproj.f -Mdir obj_dir -o aluSim

run: compile
	-$(SIM) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Done: errors found" sim.log; then \
		echo "Simulation failed"; exit 1; \
	elif ! grep -q "Done: no errors" sim.log; then \
		echo "Simulation ended without a result"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

/* aluproj.f */
+incdir+include
source/aluPkg.sv
source/alu.sv
source/aluRegs.sv
source/aluTop.sv
tests/aluTb.sv

/* include/alu_params.svh */
/* ALU register block constants
   Data and address widths plus the AXI4-Lite register map */

`ifndef ALU_PARAMS_SVH
`define ALU_PARAMS_SVH

// ----------------------------------------
// Widths
`define ALU_DATA_W 32
`define ALU_ADDR_W 5

// ----------------------------------------
// Register byte offsets
`define ALU_REG_A      5'h00
`define ALU_REG_B      5'h04
`define ALU_REG_OP     5'h08  // Func in [10:5], shamt in [4:0]
`define ALU_REG_RESULT 5'h0C  // Read only
`define ALU_REG_FLAGS  5'h10  // Read only, {N, O, Z, C}

`endif

/* source/alu.sv */
/* MIPS integer ALU
   Combinational result and carry, zero, overflow, negative flags */

`default_nettype none

`include "alu_params.svh"

module alu (
    input  wire logic [`ALU_DATA_W-1:0] opA,
    input  wire logic [`ALU_DATA_W-1:0] opB,
    input  wire logic [4:0]             shamt,
    input  wire aluPkg::funcE           func,
    output logic      [`ALU_DATA_W-1:0] result,
    output logic                        carry,    // Carry or borrow out
    output logic                        zero,
    output logic                        overflow,
    output logic                        negative
);

    localparam int MSB = `ALU_DATA_W - 1;

    logic [`ALU_DATA_W:0] wide;    // Sum or difference with carry bit
    logic [4:0]           varAmt;  // Variable shift amount

    // Only the low five bits of A count, as in MIPS
    assign varAmt = opA[4:0];

    // ----------------------------------------
    // Operation decode
    always_comb
    begin
        wide     = '0;
        result   = '0;
        carry    = 1'b0;
        overflow = 1'b0;

        case (func)
            aluPkg::ADD:
            begin
                wide     = {1'b0, opA} + {1'b0, opB};
                result   = wide[MSB:0];
                carry    = wide[`ALU_DATA_W];
                overflow = (opA[MSB] == opB[MSB]) && (result[MSB] != opA[MSB]);
            end

            aluPkg::ADDU:
            begin
                wide     = {1'b0, opA} + {1'b0, opB};
                result   = wide[MSB:0];
                carry    = wide[`ALU_DATA_W];
                overflow = carry;   // Unsigned form mirrors the carry
            end

            aluPkg::SUB:
            begin
                wide     = {1'b0, opA} - {1'b0, opB};
                result   = wide[MSB:0];
                carry    = wide[`ALU_DATA_W];
                // Signs differ and result sign flips away from A
                overflow = (opA[MSB] != opB[MSB]) && (result[MSB] != opA[MSB]);
            end

            aluPkg::SUBU:
            begin
                wide     = {1'b0, opA} - {1'b0, opB};
                result   = wide[MSB:0];
                carry    = wide[`ALU_DATA_W];  // Borrow
                overflow = carry;
            end

            aluPkg::SLL:  result = opB << shamt;
            aluPkg::SLLV: result = opB << varAmt;
            aluPkg::SRA:  result = $signed(opB) >>> shamt;
            aluPkg::SRAV: result = $signed(opB) >>> varAmt;
            aluPkg::SRL:  result = opB >> shamt;
            aluPkg::SRLV: result = opB >> varAmt;

            aluPkg::AND:  result = opA & opB;
            aluPkg::NOR:  result = ~(opA | opB);
            aluPkg::OR:   result = opA | opB;
            aluPkg::XOR:  result = opA ^ opB;

            // Conditional write is decided elsewhere
            aluPkg::MOVN,
            aluPkg::MOVZ: result = opA;

            aluPkg::SLT:  result[0] = $signed(opA) < $signed(opB);
            aluPkg::SLTU: result[0] = opA < opB;

            default:      result = '0;  // Undefined code
        endcase
    end

    // ----------------------------------------
    // Result flags
    assign negative = result[MSB];
    assign zero     = (result == '0);

endmodule

`default_nettype wire

/* source/aluPkg.sv */
/* ALU package
   Function codes, AXI response codes and register selects */

`default_nettype none

package aluPkg;

    // MIPS funct field encodings
    typedef enum logic [5:0] {
        SLL  = 6'h00,
        SRL  = 6'h02,
        SRA  = 6'h03,
        SLLV = 6'h04,
        SRLV = 6'h06,
        SRAV = 6'h07,
        MOVZ = 6'h0A,
        MOVN = 6'h0B,
        ADD  = 6'h20,
        ADDU = 6'h21,
        SUB  = 6'h22,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        XOR  = 6'h26,
        NOR  = 6'h27,
        SLT  = 6'h2A,
        SLTU = 6'h2B
    } funcE;

    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        SLVERR = 2'b10
    } respE;

    // Decoded register address
    typedef enum logic [2:0] {
        REG_A, REG_B, REG_OP, REG_RESULT, REG_FLAGS, REG_NONE
    } regSelE;

endpackage

`default_nettype wire

/* source/aluRegs.sv */
/* AXI4-Lite register block for the ALU
   Holds operands and operation word, returns result and flags */

`default_nettype none

`include "alu_params.svh"

module aluRegs (
    input  wire logic                       clk,
    input  wire logic                       rstN,
    // Write address
    input  wire logic                       awvalid,
    output logic                            awready,
    input  wire logic [`ALU_ADDR_W-1:0]     awaddr,
    // Write data, strobes ignored
    input  wire logic                       wvalid,
    output logic                            wready,
    input  wire logic [`ALU_DATA_W-1:0]     wdata,
    input  wire logic [`ALU_DATA_W/8-1:0]   wstrb,
    // Write response
    output logic                            bvalid,
    input  wire logic                       bready,
    output aluPkg::respE                    bresp,
    // Read address
    input  wire logic                       arvalid,
    output logic                            arready,
    input  wire logic [`ALU_ADDR_W-1:0]     araddr,
    // Read data
    output logic                            rvalid,
    input  wire logic                       rready,
    output logic      [`ALU_DATA_W-1:0]     rdata,
    output aluPkg::respE                    rresp,
    // To the ALU
    output logic      [`ALU_DATA_W-1:0]     opA,
    output logic      [`ALU_DATA_W-1:0]     opB,
    output logic      [4:0]                 shamt,
    output aluPkg::funcE                    func,
    // From the ALU
    input  wire logic [`ALU_DATA_W-1:0]     result,
    input  wire logic                       carry,
    input  wire logic                       zero,
    input  wire logic                       overflow,
    input  wire logic                       negative
);

    aluPkg::regSelE             wrSel;
    aluPkg::regSelE             rdSel;
    logic                       wrFire;
    logic                       rdFire;
    logic                       wrOk;     // Writable register hit
    logic [`ALU_DATA_W-1:0]     rdNext;
    aluPkg::respE               rdResp;

    function automatic aluPkg::regSelE decodeAddr(input logic [`ALU_ADDR_W-1:0] addr);
        aluPkg::regSelE sel;
        case (addr)
            `ALU_REG_A:      sel = aluPkg::REG_A;
            `ALU_REG_B:      sel = aluPkg::REG_B;
            `ALU_REG_OP:     sel = aluPkg::REG_OP;
            `ALU_REG_RESULT: sel = aluPkg::REG_RESULT;
            `ALU_REG_FLAGS:  sel = aluPkg::REG_FLAGS;
            default:         sel = aluPkg::REG_NONE;
        endcase
        return sel;
    endfunction

    // ----------------------------------------
    // Handshakes, one outstanding per channel
    assign awready = !bvalid;
    assign wready  = !bvalid;
    assign arready = !rvalid;

    assign wrFire = awvalid && wvalid && awready && wready;
    assign rdFire = arvalid && arready;

    assign wrSel = decodeAddr(awaddr);
    assign rdSel = decodeAddr(araddr);
    assign wrOk  = (wrSel == aluPkg::REG_A) || (wrSel == aluPkg::REG_B)
                || (wrSel == aluPkg::REG_OP);

    // ----------------------------------------
    // Operand registers and response valids
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            opA    <= '0;
            opB    <= '0;
            shamt  <= '0;
            func   <= aluPkg::SLL;
            bvalid <= 1'b0;
            rvalid <= 1'b0;
        end
        else
        begin
            if (wrFire)
            begin
                case (wrSel)
                    aluPkg::REG_A: opA <= wdata;
                    aluPkg::REG_B: opB <= wdata;
                    aluPkg::REG_OP:
                    begin
                        shamt <= wdata[4:0];
                        func  <= aluPkg::funcE'(wdata[10:5]);  // Kept even if undefined
                    end
                    default: ;  // Read-only or unmapped
                endcase
            end

            if (wrFire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;

            if (rdFire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // ----------------------------------------
    // Read mux over registers and live ALU outputs
    always_comb
    begin
        rdNext = '0;
        rdResp = aluPkg::OKAY;
        case (rdSel)
            aluPkg::REG_A:      rdNext = opA;
            aluPkg::REG_B:      rdNext = opB;
            aluPkg::REG_OP:     rdNext = {{(`ALU_DATA_W-11){1'b0}}, func, shamt};
            aluPkg::REG_RESULT: rdNext = result;
            aluPkg::REG_FLAGS:
                rdNext = {{(`ALU_DATA_W-4){1'b0}}, negative, overflow, zero, carry};
            default:            rdResp = aluPkg::SLVERR;
        endcase
    end

    // Response payloads, held until the next accept
    always_ff @(posedge clk)
    begin
        if (wrFire)
            bresp <= wrOk ? aluPkg::OKAY : aluPkg::SLVERR;
        if (rdFire)
        begin
            rdata <= rdNext;
            rresp <= rdResp;
        end
    end

endmodule

`default_nettype wire

/* source/aluTop.sv */
/* ALU top level
   AXI4-Lite register block joined to the combinational ALU */

`default_nettype none

`include "alu_params.svh"

module aluTop (
    input  wire logic                       clk,
    input  wire logic                       rstN,
    input  wire logic                       awvalid,
    output logic                            awready,
    input  wire logic [`ALU_ADDR_W-1:0]     awaddr,
    input  wire logic                       wvalid,
    output logic                            wready,
    input  wire logic [`ALU_DATA_W-1:0]     wdata,
    input  wire logic [`ALU_DATA_W/8-1:0]   wstrb,
    output logic                            bvalid,
    input  wire logic                       bready,
    output aluPkg::respE                    bresp,
    input  wire logic                       arvalid,
    output logic                            arready,
    input  wire logic [`ALU_ADDR_W-1:0]     araddr,
    output logic                            rvalid,
    input  wire logic                       rready,
    output logic      [`ALU_DATA_W-1:0]     rdata,
    output aluPkg::respE                    rresp
);

    // Register block to ALU
    logic [`ALU_DATA_W-1:0] opA;
    logic [`ALU_DATA_W-1:0] opB;
    logic [4:0]             shamt;
    aluPkg::funcE           func;

    // ALU back to register block
    logic [`ALU_DATA_W-1:0] result;
    logic                   carry;
    logic                   zero;
    logic                   overflow;
    logic                   negative;

    aluRegs regs_i (
        .clk      (clk),
        .rstN     (rstN),
        .awvalid  (awvalid),
        .awready  (awready),
        .awaddr   (awaddr),
        .wvalid   (wvalid),
        .wready   (wready),
        .wdata    (wdata),
        .wstrb    (wstrb),
        .bvalid   (bvalid),
        .bready   (bready),
        .bresp    (bresp),
        .arvalid  (arvalid),
        .arready  (arready),
        .araddr   (araddr),
        .rvalid   (rvalid),
        .rready   (rready),
        .rdata    (rdata),
        .rresp    (rresp),
        .opA      (opA),
        .opB      (opB),
        .shamt    (shamt),
        .func     (func),
        .result   (result),
        .carry    (carry),
        .zero     (zero),
        .overflow (overflow),
        .negative (negative)
    );

    alu alu_i (
        .opA      (opA),
        .opB      (opB),
        .shamt    (shamt),
        .func     (func),
        .result   (result),
        .carry    (carry),
        .zero     (zero),
        .overflow (overflow),
        .negative (negative)
    );

endmodule

`default_nettype wire

/* tests/aluTb.sv */
/* ALU register block testbench
   AXI4-Lite driver, reference model and response checker */

`default_nettype none

`include "alu_params.svh"

module aluTb;

    localparam int     NumTrans  = 1220;                    // Transfers issued by all tests
    localparam int     TimeLimit = NumTrans * 40 * 10 + 2000;
    localparam longint MaxS      = 64'sd2147483647;
    localparam longint MinS      = -64'sd2147483648;

    logic clk, rstN;
    logic awvalid, awready, wvalid, wready, bvalid, bready;
    logic arvalid, arready, rvalid, rready;
    logic [`ALU_ADDR_W-1:0]   awaddr, araddr;
    logic [`ALU_DATA_W-1:0]   wdata, rdata;
    logic [`ALU_DATA_W/8-1:0] wstrb;
    aluPkg::respE             bresp, rresp;

    int  seed = 32'h2a2e0a6a;
    bit  holdPending = 1'b0;                 // Read data waiting on rready
    bit  wrBusy = 1'b0;                      // Write accepted and response not yet taken
    bit  rdBusy = 1'b0;                      // Read accepted and data not yet taken
    logic [`ALU_DATA_W-1:0] heldData;

    // Expected responses in arrival order
    aluPkg::respE           expBResp [$];
    aluPkg::regSelE         expSel [$];
    logic [`ALU_DATA_W-1:0] expRData [$];
    aluPkg::respE           expRResp [$];

    aluPkg::funcE allFuncs [18] = '{aluPkg::SLL, aluPkg::SRL, aluPkg::SRA, aluPkg::SLLV,
        aluPkg::SRLV, aluPkg::SRAV, aluPkg::MOVZ, aluPkg::MOVN, aluPkg::ADD, aluPkg::ADDU,
        aluPkg::SUB, aluPkg::SUBU, aluPkg::AND, aluPkg::OR, aluPkg::XOR, aluPkg::NOR,
        aluPkg::SLT, aluPkg::SLTU};
    aluPkg::funcE shiftFns [6] = '{aluPkg::SLL, aluPkg::SLLV, aluPkg::SRA, aluPkg::SRAV,
        aluPkg::SRL, aluPkg::SRLV};
    logic [4:0]   shiftAmts [3] = '{5'd0, 5'd7, 5'd31};

    aluTop dut_i (.*);

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ----------------------------------------
    // Reference model with flags as {N, O, Z, C}
    function automatic void refAlu(input logic [31:0] a, input logic [31:0] b,
                                   input logic [4:0] sh, input logic [5:0] fn,
                                   output logic [31:0] res, output logic [3:0] flags);
        logic [63:0] uWide;
        longint      sWide;
        logic        c;
        logic        o;
        logic [4:0]  n;
        c = 1'b0;
        o = 1'b0;
        n = (fn == aluPkg::SLLV || fn == aluPkg::SRLV || fn == aluPkg::SRAV) ? a[4:0] : sh;
        case (fn)
            aluPkg::ADD, aluPkg::ADDU:
            begin
                uWide = {32'b0, a} + {32'b0, b};
                sWide = longint'($signed(a)) + longint'($signed(b));
                res   = uWide[31:0];
                c     = uWide[32];
                o     = (fn == aluPkg::ADD) ? (sWide > MaxS || sWide < MinS) : c;
            end
            aluPkg::SUB, aluPkg::SUBU:
            begin
                sWide = longint'($signed(a)) - longint'($signed(b));
                res   = a - b;
                c     = a < b;               // Borrow
                o     = (fn == aluPkg::SUB) ? (sWide > MaxS || sWide < MinS) : c;
            end
            aluPkg::SLL, aluPkg::SLLV: res = b << n;
            aluPkg::SRL, aluPkg::SRLV: res = b >> n;
            aluPkg::SRA, aluPkg::SRAV: res = (b >> n) | (b[31] ? ~(32'hFFFF_FFFF >> n) : 32'h0);
            aluPkg::AND:  res = a & b;
            aluPkg::OR:   res = a | b;
            aluPkg::XOR:  res = a ^ b;
            aluPkg::NOR:  res = ~(a | b);
            aluPkg::MOVN, aluPkg::MOVZ: res = a;
            aluPkg::SLT:  res = {31'b0, ($signed(a) < $signed(b))};
            aluPkg::SLTU: res = {31'b0, (a < b)};
            default:      res = '0;
        endcase
        flags = {res[31], o, (res == 32'h0), c};
    endfunction

    function automatic logic [31:0] opWord(input logic [5:0] fn, input logic [4:0] sh);
        return {21'b0, fn, sh};
    endfunction

    function automatic aluPkg::regSelE selOf(input logic [`ALU_ADDR_W-1:0] addr);
        case (addr)
            `ALU_REG_A:      return aluPkg::REG_A;
            `ALU_REG_B:      return aluPkg::REG_B;
            `ALU_REG_OP:     return aluPkg::REG_OP;
            `ALU_REG_RESULT: return aluPkg::REG_RESULT;
            `ALU_REG_FLAGS:  return aluPkg::REG_FLAGS;
            default:         return aluPkg::REG_NONE;
        endcase
    endfunction

    // ----------------------------------------
    // Failure handling and compare tasks
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic checkData(input string name, input logic [`ALU_DATA_W-1:0] exp,
                             input logic [`ALU_DATA_W-1:0] act);
        if (act !== exp)
            abortRun($sformatf("Error at %0t: %s expected %h got %h", $time, name, exp, act));
    endtask

    task automatic checkFlags(input string name, input logic [3:0] exp, input logic [3:0] act);
        if (act !== exp)
            abortRun($sformatf("Error at %0t: %s expected %b got %b", $time, name, exp, act));
    endtask

    task automatic checkResp(input string name, input aluPkg::respE exp, input aluPkg::respE act);
        if (act !== exp)
            abortRun($sformatf("Error at %0t: %s expected %s got %b", $time, name,
                               exp.name(), act));
    endtask

    task automatic checkBit(input string name, input logic exp, input logic act);
        if (act !== exp)
            abortRun($sformatf("Error at %0t: %s expected %b got %b", $time, name, exp, act));
    endtask

    // ----------------------------------------
    // AXI4-Lite transfers with a random wait before the response
    task automatic axiWrite(input logic [`ALU_ADDR_W-1:0] addr,
                            input logic [`ALU_DATA_W-1:0] data);
        int idle;
        awvalid <= 1'b1;
        awaddr  <= addr;
        wvalid  <= 1'b1;
        wdata   <= data;
        @(posedge clk);
        while (!(awready && wready))
            @(posedge clk);
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        idle = $unsigned($random(seed)) % 4;
        repeat (idle) @(posedge clk);
        bready <= 1'b1;
        @(posedge clk);
        while (!bvalid)
            @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axiRead(input logic [`ALU_ADDR_W-1:0] addr);
        int idle;
        arvalid <= 1'b1;
        araddr  <= addr;
        @(posedge clk);
        while (!arready)
            @(posedge clk);
        arvalid <= 1'b0;
        idle = $unsigned($random(seed)) % 4;
        repeat (idle) @(posedge clk);  // Data must hold meanwhile
        rready <= 1'b1;
        @(posedge clk);
        while (!rvalid)
            @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic writeReg(input logic [`ALU_ADDR_W-1:0] addr,
                            input logic [`ALU_DATA_W-1:0] data, input aluPkg::respE resp);
        expBResp.push_back(resp);
        axiWrite(addr, data);
    endtask

    task automatic readReg(input logic [`ALU_ADDR_W-1:0] addr,
                           input logic [`ALU_DATA_W-1:0] data, input aluPkg::respE resp);
        expSel.push_back(selOf(addr));
        expRData.push_back(data);
        expRResp.push_back(resp);
        axiRead(addr);
    endtask

    // Load operands and op word then read result and flags
    task automatic runCase(input logic [31:0] a, input logic [31:0] b,
                           input logic [4:0] sh, input logic [5:0] fn);
        logic [31:0] res;
        logic [3:0]  flags;
        refAlu(a, b, sh, fn, res, flags);
        writeReg(`ALU_REG_A, a, aluPkg::OKAY);
        writeReg(`ALU_REG_B, b, aluPkg::OKAY);
        writeReg(`ALU_REG_OP, opWord(fn, sh), aluPkg::OKAY);
        readReg(`ALU_REG_RESULT, res, aluPkg::OKAY);
        readReg(`ALU_REG_FLAGS, {28'b0, flags}, aluPkg::OKAY);
    endtask

    // ----------------------------------------
    // Ready and response checker on all channels
    always @(posedge clk)
    begin : compare
        aluPkg::regSelE         sel;
        logic [`ALU_DATA_W-1:0] eData;
        aluPkg::respE           eResp;
        // Ready only while no response of that channel is outstanding
        if (rstN)
        begin
            checkBit("awready", !wrBusy, awready);
            checkBit("wready", !wrBusy, wready);
            checkBit("arready", !rdBusy, arready);
        end
        if (awvalid && wvalid && awready && wready)
            wrBusy = 1'b1;
        else if (bvalid && bready)
            wrBusy = 1'b0;
        if (arvalid && arready)
            rdBusy = 1'b1;
        else if (rvalid && rready)
            rdBusy = 1'b0;
        if (bvalid && bready)
        begin
            if (expBResp.size() == 0)
                abortRun("Write response arrived with no write pending");
            else
                checkResp("bresp", expBResp.pop_front(), bresp);
        end
        if (holdPending && !rvalid)
            abortRun("rvalid dropped before rready was given");
        else if (holdPending)
            checkData("rdata under back-pressure", heldData, rdata);
        holdPending = rvalid && !rready;
        heldData    = rdata;
        if (rvalid && rready)
        begin
            if (expSel.size() == 0)
                abortRun("Read data arrived with no read pending");
            else
            begin
                sel   = expSel.pop_front();
                eData = expRData.pop_front();
                eResp = expRResp.pop_front();
                checkResp($sformatf("rresp %s", sel.name()), eResp, rresp);
                if (sel == aluPkg::REG_FLAGS)
                    checkFlags("rdata FLAGS", eData[3:0], rdata[3:0]);
                checkData($sformatf("rdata %s", sel.name()), eData, rdata);
            end
        end
    end

    initial
    begin
        #(TimeLimit);
        abortRun("Timeout: the tests did not finish in the expected time");
    end

    // ----------------------------------------
    // Stimulus
    initial
    begin
        logic [31:0] a;
        logic [31:0] b;
        logic [4:0]  sh;
        logic [4:0]  k;
        rstN    <= 1'b0;
        awvalid <= 1'b0;
        awaddr  <= '0;
        wvalid  <= 1'b0;
        wdata   <= '0;
        wstrb   <= '1;
        bready  <= 1'b0;
        arvalid <= 1'b0;
        araddr  <= '0;
        rready  <= 1'b0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        @(posedge clk);

        // Reset state with only the zero flag set
        readReg(`ALU_REG_A, 32'h0, aluPkg::OKAY);
        readReg(`ALU_REG_B, 32'h0, aluPkg::OKAY);
        readReg(`ALU_REG_OP, 32'h0, aluPkg::OKAY);
        readReg(`ALU_REG_RESULT, 32'h0, aluPkg::OKAY);
        readReg(`ALU_REG_FLAGS, 32'h2, aluPkg::OKAY);

        // Add, subtract and compare around the sign boundary
        runCase(32'h0000_0001, 32'h0000_0002, 5'd0, aluPkg::ADD);
        runCase(32'h7FFF_FFFF, 32'h0000_0001, 5'd0, aluPkg::ADD);
        runCase(32'h8000_0000, 32'h8000_0000, 5'd0, aluPkg::ADD);
        runCase(32'hFFFF_FFFF, 32'h0000_0001, 5'd0, aluPkg::ADD);
        runCase(32'h0000_0005, 32'h0000_0003, 5'd0, aluPkg::SUB);
        runCase(32'h8000_0000, 32'h0000_0001, 5'd0, aluPkg::SUB);
        runCase(32'h7FFF_FFFF, 32'hFFFF_FFFF, 5'd0, aluPkg::SUB);
        runCase(32'h0000_0003, 32'h0000_0005, 5'd0, aluPkg::SUB);
        runCase(32'hFFFF_FFFF, 32'h0000_0002, 5'd0, aluPkg::ADDU);
        runCase(32'h0000_0000, 32'h0000_0001, 5'd0, aluPkg::SUBU);
        runCase(32'h0000_0010, 32'h0000_0010, 5'd0, aluPkg::SUBU);
        runCase(32'hFFFF_FFFF, 32'h0000_0000, 5'd0, aluPkg::SLT);
        runCase(32'h7FFF_FFFF, 32'h8000_0000, 5'd0, aluPkg::SLT);
        runCase(32'hFFFF_FFFF, 32'h0000_0000, 5'd0, aluPkg::SLTU);
        runCase(32'h0000_0000, 32'h8000_0000, 5'd0, aluPkg::SLTU);

        // Shifts with A above 31 and a shamt field unlike A[4:0]
        foreach (shiftFns[f])
            foreach (shiftAmts[s])
                runCase(32'hABCD_EF20 | {27'b0, shiftAmts[s]}, 32'h8765_4321,
                        5'd31 - shiftAmts[s], shiftFns[f]);
        runCase(32'hF0F0_1234, 32'h0FF0_5678, 5'd0, aluPkg::AND);
        runCase(32'hF0F0_1234, 32'h0FF0_5678, 5'd0, aluPkg::OR);
        runCase(32'hF0F0_1234, 32'h0FF0_5678, 5'd0, aluPkg::XOR);
        runCase(32'hF0F0_1234, 32'h0FF0_5678, 5'd0, aluPkg::NOR);
        runCase(32'hF0F0_1234, 32'h0FF0_5678, 5'd0, aluPkg::MOVN);
        runCase(32'h0000_0000, 32'h0FF0_5678, 5'd0, aluPkg::MOVZ);

        for (int i = 0; i < 200; i++)
        begin
            a  = $random(seed);
            b  = $random(seed);
            sh = 5'($random(seed));
            k  = 5'($unsigned($random(seed)) % 18);
            runCase(a, b, sh, allFuncs[k]);
        end

        // Error responses leave the registers alone
        runCase(32'h1111_2222, 32'h3333_4444, 5'd9, aluPkg::ADD);
        writeReg(`ALU_REG_RESULT, 32'hFFFF_FFFF, aluPkg::SLVERR);
        writeReg(`ALU_REG_FLAGS, 32'hFFFF_FFFF, aluPkg::SLVERR);
        writeReg(5'h14, 32'hDEAD_BEEF, aluPkg::SLVERR);
        writeReg(5'h1C, 32'hDEAD_BEEF, aluPkg::SLVERR);
        readReg(`ALU_REG_A, 32'h1111_2222, aluPkg::OKAY);
        readReg(`ALU_REG_B, 32'h3333_4444, aluPkg::OKAY);
        readReg(`ALU_REG_OP, opWord(aluPkg::ADD, 5'd9), aluPkg::OKAY);
        readReg(5'h14, 32'h0, aluPkg::SLVERR);
        readReg(5'h18, 32'h0, aluPkg::SLVERR);
        runCase(32'h0000_1234, 32'h0000_5678, 5'd3, 6'h3F);   // Undefined code
        readReg(`ALU_REG_OP, opWord(6'h3F, 5'd3), aluPkg::OKAY);

        @(posedge clk);
        if (expBResp.size() != 0 || expSel.size() != 0)
            abortRun("Some expected responses never arrived");
        else
        begin
            $display("Done: no errors");
            $finish;
        end
    end

endmodule

`default_nettype wire
